// ==== soc_pkg.sv ====
// Memory map, bus codes and address views for a 32-bit byte-addressed Wishbone fabric
`default_nettype none

package soc_pkg;

  // ============================
  // Memory map
  // ============================
  // Region picked by address bits 31..28
  localparam int unsigned region_shift = 28;

  localparam logic [31:0] ram_base   = 32'h8000_0000;
  localparam logic [31:0] clint_base = 32'h3000_0000;
  localparam logic [31:0] pbus_base  = 32'h2000_0000;

  // ============================
  // Wishbone cycle types
  // ============================
  localparam logic [2:0] wb_cti_classic = 3'b000;
  localparam logic [2:0] wb_cti_incr    = 3'b010;
  localparam logic [2:0] wb_cti_eob     = 3'b111;

  // Cache line geometry
  localparam int unsigned line_w         = 128;
  localparam int unsigned words_per_line = 4;

  // ============================
  // CLINT register offsets
  // ============================
  localparam logic [15:0] clint_msip_off        = 16'h0000;
  localparam logic [15:0] clint_mtimecmp_lo_off = 16'h4000;
  localparam logic [15:0] clint_mtimecmp_hi_off = 16'h4004;
  localparam logic [15:0] clint_mtime_lo_off    = 16'hBFF8;
  localparam logic [15:0] clint_mtime_hi_off    = 16'hBFFC;

  // Byte address, seen by RAM and CLINT in two ways
  typedef union packed {
    // Line RAM view
    struct packed {
      logic [3:0]  region;
      logic [23:0] line_idx;
      logic [1:0]  word_off;
      logic [1:0]  byte_off;
    } ram;
    // CLINT register view
    struct packed {
      logic [3:0]  region;
      logic [11:0] rsvd;
      logic [15:0] reg_off;
    } clint;
  } wb_addr_u;

endpackage

`default_nettype wire

// ==== wb_decoder.sv ====
// Combinational region decode on address bits 31..28; unmapped and peripheral space acks at once
`timescale 1ns/10ps
`default_nettype none

module wb_decoder (
  // Master side
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [31:0] wb_adr_i,
  output logic        wb_ack_o,
  output logic [31:0] wb_dat_o,

  // RAM slave
  output logic        ram_stb_o,
  input  logic        ram_ack_i,
  input  logic [31:0] ram_dat_i,

  // CLINT slave
  output logic        clint_stb_o,
  input  logic        clint_ack_i,
  input  logic [31:0] clint_dat_i
);
  import soc_pkg::*;

  // Region codes taken from the base addresses
  localparam logic [3:0] ram_region   = 4'(ram_base >> region_shift);
  localparam logic [3:0] clint_region = 4'(clint_base >> region_shift);

  wb_addr_u adr_u;
  logic     req;

  assign adr_u = wb_adr_i;

  // Valid beat on the bus
  assign req = wb_cyc_i && wb_stb_i;

  // ============================
  // Select and response mux
  // ============================
  always_comb begin
    ram_stb_o   = 1'b0;
    clint_stb_o = 1'b0;
    case (adr_u.ram.region)
      ram_region: begin
        ram_stb_o = req;
        wb_ack_o  = ram_ack_i;
        wb_dat_o  = ram_dat_i;
      end
      clint_region: begin
        clint_stb_o = req;
        wb_ack_o    = clint_ack_i;
        wb_dat_o    = clint_dat_i;
      end
      default: begin
        // Peripheral block and unmapped space read as zero and ready
        wb_ack_o = req;
        wb_dat_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== line_ram.sv ====
// Line-wide RAM with byte write strobes and one-cycle registered read; contents power up unknown
`timescale 1ns/10ps
`default_nettype none

module line_ram #(
  parameter int unsigned RAM_WORDS = 1024
) (
  input  logic                                                  clk_i,
  input  logic [$clog2(RAM_WORDS/soc_pkg::words_per_line)-1:0] addr_i,
  input  logic [soc_pkg::line_w-1:0]                            wdata_i,
  input  logic [soc_pkg::line_w/8-1:0]                          wstrb_i,
  input  logic                                                  rd_en_i,
  output logic [soc_pkg::line_w-1:0]                            rdata_o
);
  import soc_pkg::*;

  localparam int unsigned lines = RAM_WORDS / words_per_line;

  // Storage array
  logic [line_w-1:0] mem [lines];

  // Byte-granular write
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < line_w / 8; b++) begin
      if (wstrb_i[b]) begin
        mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // Registered read, old data on a same-edge write
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== ram_wb_adapter.sv ====
// Wishbone-to-line RAM bridge; RAM_LATENCY >= 2, bursts must start at word 0 and end with EOB
`timescale 1ns/10ps
`default_nettype none

module ram_wb_adapter #(
  parameter int unsigned RAM_WORDS   = 1024,
  parameter int unsigned RAM_LATENCY = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  input  logic [3:0]  sel_i,
  input  logic [2:0]  cti_i,
  output logic        ack_o,
  output logic [31:0] dat_o
);
  import soc_pkg::*;

  localparam int unsigned line_aw = $clog2(RAM_WORDS / words_per_line);

  wb_addr_u            adr_u;
  logic [1:0]          word_off;
  logic [line_aw-1:0]  line_addr;

  // Line RAM side
  logic [line_w-1:0]   wr_line;
  logic [line_w/8-1:0] wr_strb;
  logic                rd_en;
  logic [line_w-1:0]   rd_line;

  // Read latency tracking
  logic                   pending_q;
  logic [RAM_LATENCY-1:0] delay_q;
  logic                   lat_done;

  // Burst line buffer
  logic [line_w-1:0] buf_q;
  logic              buf_valid_q;
  logic              burst_ack;
  logic              wr_ack;

  assign adr_u     = adr_i;
  assign word_off  = adr_u.ram.word_off;
  assign line_addr = adr_u.ram.line_idx[line_aw-1:0];

  // ============================
  // Write expansion
  // ============================
  always_comb begin
    wr_strb = '0;
    // Same word in every lane, strobes pick the lane
    for (int w = 0; w < words_per_line; w++) begin
      wr_line[w*32 +: 32] = dat_i;
    end
    if (stb_i && we_i) begin
      wr_strb[word_off*4 +: 4] = sel_i;
    end
  end

  // New line read only when the buffer is empty
  assign rd_en = stb_i && !we_i && !buf_valid_q;

  line_ram #(
    .RAM_WORDS(RAM_WORDS)
  ) i_line_ram (
    .clk_i  (clk_i),
    .addr_i (line_addr),
    .wdata_i(wr_line),
    .wstrb_i(wr_strb),
    .rd_en_i(rd_en),
    .rdata_o(rd_line)
  );

  // ============================
  // Acknowledge generation
  // ============================
  assign lat_done  = delay_q[RAM_LATENCY-1];
  assign wr_ack    = stb_i && we_i;
  // Later burst beats hit the buffer
  assign burst_ack = stb_i && !we_i && buf_valid_q && (cti_i != wb_cti_classic);
  assign ack_o     = wr_ack || lat_done || burst_ack;

  // Latency shift register, flushed on any ack
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else if (ack_o) begin
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else begin
      pending_q <= rd_en;
      delay_q   <= {delay_q[RAM_LATENCY-2:0], pending_q};
    end
  end

  // Buffer state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (lat_done && (cti_i == wb_cti_incr)) begin
      // First beat of an incrementing burst
      buf_valid_q <= 1'b1;
    end else if (burst_ack && (cti_i == wb_cti_eob)) begin
      buf_valid_q <= 1'b0;
    end else if (buf_valid_q && stb_i && (we_i || cti_i == wb_cti_classic)) begin
      // Burst abandoned, drop the stale line
      buf_valid_q <= 1'b0;
    end
  end

  // Line capture when the latency expires
  always_ff @(posedge clk_i) begin
    if (lat_done) begin
      buf_q <= rd_line;
    end
  end

  // Word select from buffer or live line
  always_comb begin
    if (buf_valid_q) begin
      dat_o = buf_q[word_off*32 +: 32];
    end else begin
      dat_o = rd_line[word_off*32 +: 32];
    end
  end

endmodule

`default_nettype wire

// ==== clint.sv ====
// Single-hart CLINT; mtime ticks every clk_i, registered ack one cycle after stb, unknown offsets read 0
`timescale 1ns/10ps
`default_nettype none

module clint (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  input  logic [3:0]  sel_i,
  output logic        ack_o,
  output logic [31:0] dat_o,
  output logic        timer_irq_o,
  output logic        sw_irq_o
);
  import soc_pkg::*;

  wb_addr_u    adr_u;
  logic [15:0] reg_off;
  logic        access;
  logic        wr_en;
  logic        ack_q;
  logic        msip_q;
  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_q;
  logic [31:0] rdata_d;
  logic [31:0] dat_q;

  // Merge new bytes into a word under the strobes
  function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign adr_u   = adr_i;
  assign reg_off = adr_u.clint.reg_off;

  // One access per strobe, the ack cycle is skipped
  assign access = stb_i && !ack_q;
  assign wr_en  = access && we_i;

  // ============================
  // mtime next value
  // ============================
  always_comb begin
    mtime_d = mtime_q + 64'd1;
    if (wr_en && reg_off == clint_mtime_lo_off) begin
      mtime_d[31:0] = byte_merge(mtime_q[31:0], dat_i, sel_i);
    end
    if (wr_en && reg_off == clint_mtime_hi_off) begin
      mtime_d[63:32] = byte_merge(mtime_q[63:32], dat_i, sel_i);
    end
  end

  // Control registers
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      msip_q     <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      ack_q   <= access;
      mtime_q <= mtime_d;
      if (wr_en) begin
        case (reg_off)
          clint_msip_off: if (sel_i[0]) msip_q <= dat_i[0];
          clint_mtimecmp_lo_off:
            mtimecmp_q[31:0] <= byte_merge(mtimecmp_q[31:0], dat_i, sel_i);
          clint_mtimecmp_hi_off:
            mtimecmp_q[63:32] <= byte_merge(mtimecmp_q[63:32], dat_i, sel_i);
          default: ;
        endcase
      end
    end
  end

  // Read mux
  always_comb begin
    case (reg_off)
      clint_msip_off:        rdata_d = {31'b0, msip_q};
      clint_mtimecmp_lo_off: rdata_d = mtimecmp_q[31:0];
      clint_mtimecmp_hi_off: rdata_d = mtimecmp_q[63:32];
      clint_mtime_lo_off:    rdata_d = mtime_q[31:0];
      clint_mtime_hi_off:    rdata_d = mtime_q[63:32];
      default:               rdata_d = '0;
    endcase
  end

  // Read data sampled with the ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_q <= rdata_d;
    end
  end

  assign ack_o       = ack_q;
  assign dat_o       = dat_q;
  assign sw_irq_o    = msip_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// ==== soc_fabric.sv ====
// Wishbone slave fabric for one master; no stall, err or rty, peripheral space returns zero
`timescale 1ns/10ps
`default_nettype none

module soc_fabric #(
  parameter int unsigned RAM_WORDS   = 1024,
  parameter int unsigned RAM_LATENCY = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Wishbone slave port
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [2:0]  wb_cti_i,
  output logic        wb_ack_o,
  output logic [31:0] wb_dat_o,

  // Interrupts to the hart
  output logic        timer_irq_o,
  output logic        sw_irq_o
);

  // Per-slave strobes and responses
  logic        ram_stb;
  logic        ram_ack;
  logic [31:0] ram_dat;
  logic        clint_stb;
  logic        clint_ack;
  logic [31:0] clint_dat;

  // ============================
  // Address decode
  // ============================
  wb_decoder i_decoder (
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_adr_i   (wb_adr_i),
    .wb_ack_o   (wb_ack_o),
    .wb_dat_o   (wb_dat_o),
    .ram_stb_o  (ram_stb),
    .ram_ack_i  (ram_ack),
    .ram_dat_i  (ram_dat),
    .clint_stb_o(clint_stb),
    .clint_ack_i(clint_ack),
    .clint_dat_i(clint_dat)
  );

  // Main RAM behind the line adapter
  ram_wb_adapter #(
    .RAM_WORDS  (RAM_WORDS),
    .RAM_LATENCY(RAM_LATENCY)
  ) i_ram (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .stb_i (ram_stb),
    .we_i  (wb_we_i),
    .adr_i (wb_adr_i),
    .dat_i (wb_dat_i),
    .sel_i (wb_sel_i),
    .cti_i (wb_cti_i),
    .ack_o (ram_ack),
    .dat_o (ram_dat)
  );

  // Timer and software interrupt block
  clint i_clint (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stb_i      (clint_stb),
    .we_i       (wb_we_i),
    .adr_i      (wb_adr_i),
    .dat_i      (wb_dat_i),
    .sel_i      (wb_sel_i),
    .ack_o      (clint_ack),
    .dat_o      (clint_dat),
    .timer_irq_o(timer_irq_o),
    .sw_irq_o   (sw_irq_o)
  );

endmodule

`default_nettype wire

// ==== tb_vectors.svh ====
// Vector rows for tb_soc_fabric; RAM expected data comes from the byte model, so those exp fields are 0
// Columns: operation kind, address, write data, byte strobes, expected data

localparam int n_vectors = 38;

vec_t vector_tab [n_vectors];

task automatic load_vectors();
  // Levels right after reset
  vector_tab[0]  = '{op_tmr_irq,  32'h3000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000};
  vector_tab[1]  = '{op_sw_irq,   32'h3000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000};
  // RAM line 0, full words then partial strobes
  vector_tab[2]  = '{op_wr_rand,  32'h8000_0000, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[3]  = '{op_wr_rand,  32'h8000_0004, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[4]  = '{op_wr_rand,  32'h8000_0008, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[5]  = '{op_wr_rand,  32'h8000_000c, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[6]  = '{op_rd_model, 32'h8000_0004, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[7]  = '{op_wr_rand,  32'h8000_0004, 32'h0000_0000, 4'h5, 32'h0000_0000};
  vector_tab[8]  = '{op_rd_model, 32'h8000_0004, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[9]  = '{op_wr_rand,  32'h8000_0008, 32'h0000_0000, 4'h2, 32'h0000_0000};
  vector_tab[10] = '{op_rd_model, 32'h8000_0008, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[11] = '{op_wr_rand,  32'h8000_000c, 32'h0000_0000, 4'h8, 32'h0000_0000};
  // Burst over line 0, then single reads
  vector_tab[12] = '{op_burst,    32'h8000_0000, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[13] = '{op_rd_model, 32'h8000_000c, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[14] = '{op_wr_rand,  32'h8000_0ff0, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[15] = '{op_rd_model, 32'h8000_0ff0, 32'h0000_0000, 4'hf, 32'h0000_0000};
  // Peripheral and unmapped space
  vector_tab[16] = '{op_wr_rand,  32'h8000_0010, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[17] = '{op_wr,       32'h2000_0010, 32'hdead_beef, 4'hf, 32'h0000_0000};
  vector_tab[18] = '{op_rd_model, 32'h8000_0010, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[19] = '{op_rd,       32'h2000_0040, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[20] = '{op_rd,       32'h5000_0000, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[21] = '{op_wr,       32'h2000_0000, 32'h0000_0001, 4'hf, 32'h0000_0000};
  vector_tab[22] = '{op_sw_irq,   32'h3000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000};
  vector_tab[23] = '{op_rd,       32'h3000_0000, 32'h0000_0000, 4'hf, 32'h0000_0000};
  // msip set and clear
  vector_tab[24] = '{op_wr,       32'h3000_0000, 32'h0000_0001, 4'h1, 32'h0000_0000};
  vector_tab[25] = '{op_sw_irq,   32'h3000_0000, 32'h0000_0000, 4'h0, 32'h0000_0001};
  vector_tab[26] = '{op_rd,       32'h3000_0000, 32'h0000_0000, 4'hf, 32'h0000_0001};
  vector_tab[27] = '{op_wr,       32'h3000_0000, 32'h0000_0000, 4'h1, 32'h0000_0000};
  vector_tab[28] = '{op_sw_irq,   32'h3000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000};
  // Timer compare low, then back to all ones
  vector_tab[29] = '{op_tmr_irq,  32'h3000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000};
  vector_tab[30] = '{op_wr,       32'h3000_4004, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[31] = '{op_wr,       32'h3000_4000, 32'h0000_0100, 4'hf, 32'h0000_0000};
  vector_tab[32] = '{op_tmr_wait, 32'h3000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000};
  vector_tab[33] = '{op_mtime,    32'h3000_bff8, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[34] = '{op_rd,       32'h3000_4004, 32'h0000_0000, 4'hf, 32'h0000_0000};
  vector_tab[35] = '{op_wr,       32'h3000_4000, 32'hffff_ffff, 4'hf, 32'h0000_0000};
  vector_tab[36] = '{op_wr,       32'h3000_4004, 32'hffff_ffff, 4'hf, 32'h0000_0000};
  vector_tab[37] = '{op_tmr_irq,  32'h3000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000};
endtask

// ==== tb_soc_fabric.sv ====
// Self-checking testbench for soc_fabric; RAM rows stay in the first 4 KB and only read written words
`timescale 1ns/10ps
`default_nettype none

module tb_soc_fabric;
  import soc_pkg::*;

  localparam int unsigned ram_words   = 1024;
  localparam int unsigned ram_latency = 4;
  localparam int unsigned ack_timeout = 64;
  localparam int unsigned irq_timeout = 2000;

  // ==============================
  // Row kinds of the vector table
  // ==============================
  localparam logic [3:0] op_wr_rand  = 4'd0;
  localparam logic [3:0] op_wr       = 4'd1;
  localparam logic [3:0] op_rd_model = 4'd2;
  localparam logic [3:0] op_rd       = 4'd3;
  localparam logic [3:0] op_burst    = 4'd4;
  localparam logic [3:0] op_sw_irq   = 4'd5;
  localparam logic [3:0] op_tmr_irq  = 4'd6;
  localparam logic [3:0] op_tmr_wait = 4'd7;
  localparam logic [3:0] op_mtime    = 4'd8;

  typedef struct packed {
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  sel;
    logic [31:0] exp;
  } vec_t;

  logic        clk_i;
  logic        rst_ni;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic [2:0]  wb_cti_i;
  logic        wb_ack_o;
  logic [31:0] wb_dat_o;
  logic        timer_irq_o;
  logic        sw_irq_o;

  // LFSR state and RAM byte model
  logic [31:0] lfsr_q;
  logic [7:0]  ram_model [logic [31:0]];
  int unsigned err_cnt;
  int unsigned fail_cnt;

  `include "tb_vectors.svh"

  soc_fabric #(
    .RAM_WORDS  (ram_words),
    .RAM_LATENCY(ram_latency)
  ) DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_cti_i   (wb_cti_i),
    .wb_ack_o   (wb_ack_o),
    .wb_dat_o   (wb_dat_o),
    .timer_irq_o(timer_irq_o),
    .sw_irq_o   (sw_irq_o)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per data bit
  task automatic rand_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w      = {w[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic is_ram(input logic [31:0] adr);
    return adr[31:28] == 4'h8;
  endfunction

  task automatic model_write(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        ram_model[{adr[31:2], 2'b00} + 32'(b)] = dat[b*8 +: 8];
      end
    end
  endtask

  // Unwritten bytes come back as unknown
  function automatic logic [31:0] model_word(input logic [31:0] adr);
    logic [31:0] w;
    logic [31:0] a;
    for (int b = 0; b < 4; b++) begin
      a = {adr[31:2], 2'b00} + 32'(b);
      w[b*8 +: 8] = ram_model.exists(a) ? ram_model[a] : 8'hxx;
    end
    return w;
  endfunction

  function automatic string op_name(input logic [3:0] op);
    case (op)
      op_wr_rand:  return "write random";
      op_wr:       return "write";
      op_rd_model: return "read ram";
      op_rd:       return "read";
      op_burst:    return "burst read";
      op_sw_irq:   return "sw irq level";
      op_tmr_irq:  return "timer irq level";
      op_tmr_wait: return "timer irq wait";
      op_mtime:    return "mtime advance";
      default:     return "unknown";
    endcase
  endfunction

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // ==============================
  // Wishbone master
  // ==============================
  task automatic drive_beat(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic [2:0] cti);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_cti_i = cti;
  endtask

  // Ack sampled at the falling edge, beat ends on the next rising edge
  task automatic wait_ack(output logic [31:0] rdata);
    int unsigned n;
    logic        seen;
    n     = 0;
    seen  = 1'b0;
    rdata = '0;
    while (!seen && n < ack_timeout) begin
      @(negedge clk_i);
      if (wb_ack_o === 1'b1) begin
        seen  = 1'b1;
        rdata = wb_dat_o;
      end
      n++;
    end
    if (!seen) begin
      $display("No acknowledge within %0d cycles for address %h", ack_timeout, wb_adr_i);
      err_cnt++;
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic bus_idle();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_sel_i = 4'h0;
    wb_cti_i = wb_cti_classic;
    @(posedge clk_i);
    #2;
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused_dat;
    drive_beat(1'b1, adr, dat, sel, wb_cti_classic);
    wait_ack(unused_dat);
    bus_idle();
  endtask

  task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
    drive_beat(1'b0, adr, 32'h0, 4'hf, wb_cti_classic);
    wait_ack(dat);
    bus_idle();
  endtask

  // Four beats from word 0, last one tagged end-of-burst
  task automatic bus_burst(input logic [31:0] adr, output logic [127:0] line);
    logic [31:0] dat;
    for (int beat = 0; beat < 4; beat++) begin
      drive_beat(1'b0, adr + 32'(beat * 4), 32'h0, 4'hf,
                 (beat == 3) ? wb_cti_eob : wb_cti_incr);
      wait_ack(dat);
      line[beat*32 +: 32] = dat;
    end
    bus_idle();
  endtask

  task automatic wait_timer_irq();
    int unsigned n;
    n = 0;
    while (timer_irq_o !== 1'b1 && n < irq_timeout) begin
      @(posedge clk_i);
      #2;
      n++;
    end
    if (timer_irq_o !== 1'b1) begin
      $display("Timer interrupt did not rise within %0d cycles", irq_timeout);
      err_cnt++;
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    vec_t        v;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] first;
    logic [127:0] line;
    int unsigned errs_before;

    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = 32'h0;
    wb_dat_i = 32'h0;
    wb_sel_i = 4'h0;
    wb_cti_i = wb_cti_classic;
    rst_ni   = 1'b0;
    lfsr_q   = 32'hefd3d053;
    err_cnt  = 0;
    fail_cnt = 0;
    load_vectors();

    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #2;

    for (int i = 0; i < n_vectors; i++) begin
      v           = vector_tab[i];
      errs_before = err_cnt;
      case (v.op)
        op_wr_rand: begin
          rand_word(wdata);
          bus_write(v.addr, wdata, v.sel);
          if (is_ram(v.addr)) model_write(v.addr, wdata, v.sel);
        end
        op_wr: begin
          bus_write(v.addr, v.wdata, v.sel);
          if (is_ram(v.addr)) model_write(v.addr, v.wdata, v.sel);
        end
        op_rd_model: begin
          bus_read(v.addr, rdata);
          check_word("wb_dat_o", rdata, model_word(v.addr));
        end
        op_rd: begin
          bus_read(v.addr, rdata);
          check_word("wb_dat_o", rdata, v.exp);
        end
        op_burst: begin
          bus_burst(v.addr, line);
          for (int w = 0; w < 4; w++) begin
            check_word("wb_dat_o", line[w*32 +: 32], model_word(v.addr + 32'(w * 4)));
          end
        end
        op_sw_irq:   check_level("sw_irq_o", sw_irq_o, v.exp[0]);
        op_tmr_irq:  check_level("timer_irq_o", timer_irq_o, v.exp[0]);
        op_tmr_wait: wait_timer_irq();
        op_mtime: begin
          bus_read(v.addr, first);
          bus_read(v.addr, rdata);
          if (!(rdata > first)) begin
            $display("[FAIL] mtime_lo: second read %h not above first %h", rdata, first);
            err_cnt++;
          end
        end
        default: begin
          $display("Row %0d holds an unknown operation kind", i);
          err_cnt++;
        end
      endcase
      if (err_cnt == errs_before) begin
        $display("test %0d %s at %h: ok", i, op_name(v.op), v.addr);
      end else begin
        fail_cnt++;
        $display("test %0d %s at %h: %0d error(s)", i, op_name(v.op), v.addr,
                 err_cnt - errs_before);
      end
    end

    $display("%0d tests run, %0d failed, %0d errors", n_vectors, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
soc_pkg.sv
wb_decoder.sv
line_ram.sv
ram_wb_adapter.sv
clint.sv
soc_fabric.sv
tb_soc_fabric.sv

// ==== Makefile ====
# Verilator build and run of the Wishbone fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_fabric
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
